// ==== hdl/nnWeights.svh ====
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

// one row per neuron, one column per input
localparam fixedWord layerWeights [numNeurons][numInputs] = '{
	'{
		16'sd278, -16'sd326, 16'sd34, 16'sd130,
		-16'sd80, 16'sd458, 16'sd54, -16'sd311
	},
	'{
		-16'sd372, 16'sd95, 16'sd287, -16'sd138,
		16'sd177, 16'sd26, -16'sd115, 16'sd480
	},
	'{
		16'sd285, -16'sd7, -16'sd386, 16'sd392,
		16'sd112, -16'sd241, 16'sd73, 16'sd146
	},
	// mostly negative, so this neuron often clips to zero
	'{
		-16'sd203, 16'sd166, -16'sd54, -16'sd146,
		16'sd239, -16'sd66, -16'sd318, -16'sd12
	}
};

// added in the finish cycle of each neuron
localparam fixedWord layerBiases [numNeurons] = '{
	16'sd149,
	-16'sd57,
	16'sd12,
	-16'sd300
};

`endif

// ==== hdl/nnPkg.sv ====
`default_nettype none

package nnPkg;

	typedef logic signed [15:0] fixedWord;	// activations, weights, sums
	typedef logic [31:0] busWord;
	typedef logic [7:0] busAddr;

	typedef enum logic [1:0]
	{
		respOkay = 2'b00,
		respSlvErr = 2'b10
	} respCode;

	// layer shape
	localparam int numInputs = 8;
	localparam int numNeurons = 4;

	typedef logic [2:0] inputIndex;
	typedef logic [1:0] neuronIndex;

	// byte addresses, one 32-bit word per register
	localparam busAddr addrInputBase = 8'h00;	// inputs up to 0x1C
	localparam busAddr addrControl = 8'h20;	// bit 0 starts the layer
	localparam busAddr addrStatus = 8'h24;	// bit 0 busy, bit 1 done
	localparam busAddr addrResultBase = 8'h40;	// results up to 0x4C

	`include "nnWeights.svh"

endpackage

`default_nettype wire

// ==== hdl/activationBuffer.sv ====
`default_nettype none

module activationBuffer
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire inWrite,
	input wire inputIndex inIndex,
	input wire fixedWord inData,
	input wire inputIndex actIndex,
	output fixedWord actData,
	input wire [2:0] readIndex,
	output fixedWord inReadData,
	output fixedWord resultReadData,
	input wire resultWrite,
	input wire neuronIndex resultIndex,
	input wire fixedWord resultData
);

	fixedWord activations [numInputs];
	fixedWord results [numNeurons];

	// bus side write port
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numInputs; i++)
				activations[i] <= '0;
		end
		else if (inWrite)
			activations[inIndex] <= inData;
	end

	// engine side write port, one result per finish cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numNeurons; i++)
				results[i] <= '0;
		end
		else if (resultWrite)
			results[resultIndex] <= resultData;
	end

	assign actData = activations[actIndex];
	assign inReadData = activations[readIndex];
	assign resultReadData = results[readIndex[1:0]];	// only four result words

endmodule

`default_nettype wire

// ==== hdl/neuronEngine.sv ====
`default_nettype none

module neuronEngine
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire start,
	output logic busy,
	output logic done,
	output inputIndex actIndex,
	input wire fixedWord actData,
	output logic resultWrite,
	output neuronIndex resultIndex,
	output fixedWord resultData
);

	inputIndex inputCount;
	neuronIndex neuronCount;
	logic finishing;	// bias and ReLU cycle of the current neuron
	logic launch;
	fixedWord acc;
	fixedWord product;
	fixedWord biasedSum;

	assign launch = start && !busy;

	// product kept to 16 bits, everything wraps modulo 2^16
	assign product = actData * layerWeights[neuronCount][inputCount];
	assign biasedSum = acc + layerBiases[neuronCount];

	assign actIndex = inputCount;
	assign resultIndex = neuronCount;
	assign resultWrite = busy && finishing;
	assign resultData = biasedSum[15] ? '0 : biasedSum;	// negative sums clip to zero

	// 8 accumulate cycles then 1 finish cycle per neuron, 36 in all
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			inputCount <= '0;
			neuronCount <= '0;
			finishing <= 1'b0;
		end
		else if (launch)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			inputCount <= '0;
			neuronCount <= '0;
			finishing <= 1'b0;
		end
		else if (busy)
		begin
			if (!finishing)
			begin
				inputCount <= inputCount + 1'b1;	// wraps back to 0 for the next neuron
				if (inputCount == inputIndex'(numInputs - 1))
					finishing <= 1'b1;
			end
			else
			begin
				finishing <= 1'b0;
				neuronCount <= neuronCount + 1'b1;
				if (neuronCount == neuronIndex'(numNeurons - 1))
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// accumulator restarts at each launch and after every finish cycle
	always_ff @(posedge clk)
	begin
		if (launch || (busy && finishing))
			acc <= '0;
		else if (busy)
			acc <= acc + product;
	end

endmodule

`default_nettype wire

// ==== hdl/axiLiteRegs.sv ====
`default_nettype none

module axiLiteRegs
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire busAddr awAddr,
	input wire awValid,
	output logic awReady,
	input wire busWord wData,
	input wire wValid,
	output logic wReady,
	output respCode bResp,
	output logic bValid,
	input wire bReady,
	input wire busAddr arAddr,
	input wire arValid,
	output logic arReady,
	output busWord rData,
	output respCode rResp,
	output logic rValid,
	input wire rReady,
	output logic inWrite,
	output inputIndex inIndex,
	output fixedWord inData,
	output logic [2:0] readIndex,
	input wire fixedWord inReadData,
	input wire fixedWord resultReadData,
	output logic start,
	input wire busy,
	input wire done
);

	logic writeReq;
	logic writeFire;
	logic readFire;
	logic writeInput;
	logic writeControl;

	function automatic logic inputHit(busAddr a);
		return (a & ~8'h1C) == addrInputBase;
	endfunction

	function automatic logic resultHit(busAddr a);
		return (a & ~8'h0C) == addrResultBase;
	endfunction

	function automatic busWord signExtend(fixedWord value);
		return {{16{value[15]}}, value};
	endfunction

	// address and data must both be present and no response outstanding
	assign writeReq = awValid && wValid && !bValid && !awReady;
	assign writeFire = awReady && awValid && wReady && wValid;
	assign readFire = arReady && arValid;

	assign writeInput = inputHit(awAddr);
	assign writeControl = awAddr == addrControl;

	assign inWrite = writeFire && writeInput && !busy;	// refused while the layer runs
	assign inIndex = awAddr[4:2];
	assign inData = wData[15:0];
	assign start = writeFire && writeControl && wData[0];	// engine drops it while busy

	// word index, shared by input and result reads
	assign readIndex = arAddr[4:2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awReady <= 1'b0;
			wReady <= 1'b0;
			bValid <= 1'b0;
		end
		else
		begin
			awReady <= writeReq;
			wReady <= writeReq;
			if (writeFire)
				bValid <= 1'b1;
			else if (bReady)
				bValid <= 1'b0;
		end
	end

	// response held until bReady since it only loads on a handshake
	always_ff @(posedge clk)
	begin
		if (writeFire)
		begin
			if ((writeInput && !busy) || writeControl)
				bResp <= respOkay;
			else
				bResp <= respSlvErr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arReady <= 1'b0;
			rValid <= 1'b0;
		end
		else
		begin
			arReady <= arValid && !rValid && !arReady;
			if (readFire)
				rValid <= 1'b1;
			else if (rReady)
				rValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (readFire)
		begin
			rResp <= respOkay;
			if (inputHit(arAddr))
				rData <= signExtend(inReadData);
			else if (resultHit(arAddr))
				rData <= signExtend(resultReadData);
			else if (arAddr == addrStatus)
				rData <= {30'b0, done, busy};
			else if (arAddr == addrControl)
				rData <= '0;	// start is a pulse, nothing to read back
			else
			begin
				rData <= '0;
				rResp <= respSlvErr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/nnLayer.sv ====
`default_nettype none

module nnLayer
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire busAddr awAddr,
	input wire awValid,
	output logic awReady,
	input wire busWord wData,
	input wire wValid,
	output logic wReady,
	output respCode bResp,
	output logic bValid,
	input wire bReady,
	input wire busAddr arAddr,
	input wire arValid,
	output logic arReady,
	output busWord rData,
	output respCode rResp,
	output logic rValid,
	input wire rReady
);

	// bus block to buffer
	logic inWrite;
	inputIndex inIndex;
	fixedWord inData;
	logic [2:0] readIndex;
	fixedWord inReadData;
	fixedWord resultReadData;

	// bus block to engine
	logic start;
	logic busy;
	logic done;

	// engine to buffer
	inputIndex actIndex;
	fixedWord actData;
	logic resultWrite;
	neuronIndex resultIndex;
	fixedWord resultData;

	// port names match the wires above
	axiLiteRegs i_axiLiteRegs (.*);

	activationBuffer i_activationBuffer (.*);

	neuronEngine i_neuronEngine (.*);

endmodule

`default_nettype wire

// ==== testbench/nnLayerTb.sv ====
`default_nettype none

module nnLayerTb
	import nnPkg::*;
();

	localparam int numTransactions = 260;	// rough count over all tests
	localparam int watchdogCycles = (numTransactions + 200) * 40;

	logic clk;
	logic reset;
	busAddr awAddr;
	logic awValid;
	logic awReady;
	busWord wData;
	logic wValid;
	logic wReady;
	respCode bResp;
	logic bValid;
	logic bReady;
	busAddr arAddr;
	logic arValid;
	logic arReady;
	busWord rData;
	respCode rResp;
	logic rValid;
	logic rReady;

	integer seed;
	fixedWord acts [numInputs];	// activations last loaded into the DUT

	nnLayer i_nnLayer (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		abortRun("timeout: the tests did not finish within the allowed cycles");
	end

	task automatic checkWord(input string name, input busWord actual, input busWord expected);
		if (actual !== expected)
			abortRun($sformatf("CHECK FAILED at time %0t: %s expected %h, actual %h",
				$time, name, expected, actual));
	endtask

	task automatic checkResp(input string name, input respCode actual, input respCode expected);
		if (actual !== expected)
			abortRun($sformatf("CHECK FAILED at time %0t: %s expected %s, actual %s",
				$time, name, expected.name(), actual.name()));
	endtask

	function automatic busWord signExtended(fixedWord v);
		return {{16{v[15]}}, v};
	endfunction

	// products wrap to 16 bits, bias added, negative sums clip to zero
	function automatic fixedWord expectedResult(int n);
		fixedWord sum;
		logic signed [31:0] a;
		logic signed [31:0] w;
		logic signed [31:0] full;
		sum = layerBiases[n];
		for (int i = 0; i < numInputs; i++)
		begin
			a = {{16{acts[i][15]}}, acts[i]};
			w = {{16{layerWeights[n][i][15]}}, layerWeights[n][i]};
			full = a * w;
			sum = sum + full[15:0];
		end
		if (sum[15])
			return '0;
		else
			return sum;
	endfunction

	task automatic axiWrite(input busAddr addr, input busWord data, input int hold,
		output respCode resp);
		awAddr = addr;
		wData = data;
		awValid = 1'b1;
		wValid = 1'b1;
		do
			@(negedge clk);
		while (!(awReady && wReady));
		@(negedge clk);	// handshake took place on the rising edge just passed
		awValid = 1'b0;
		wValid = 1'b0;
		if (!bValid)
			abortRun("no write response in the cycle after the write handshake");
		resp = bResp;
		repeat (hold)
		begin
			@(negedge clk);
			if (!bValid)
				abortRun("write response dropped while bReady was low");
			checkResp("bResp held", bResp, resp);
		end
		bReady = 1'b1;
		@(negedge clk);
		bReady = 1'b0;
		if (bValid)
			abortRun("write response still valid after bReady");
	endtask

	task automatic axiRead(input busAddr addr, input int hold,
		output busWord data, output respCode resp);
		arAddr = addr;
		arValid = 1'b1;
		do
			@(negedge clk);
		while (!arReady);
		@(negedge clk);
		arValid = 1'b0;
		if (!rValid)
			abortRun("no read data in the cycle after the read handshake");
		data = rData;
		resp = rResp;
		repeat (hold)
		begin
			@(negedge clk);
			if (!rValid)
				abortRun("read data dropped while rReady was low");
			checkWord("rData held", rData, data);
			checkResp("rResp held", rResp, resp);
		end
		rReady = 1'b1;
		@(negedge clk);
		rReady = 1'b0;
		if (rValid)
			abortRun("read data still valid after rReady");
	endtask

	task automatic waitDone();
		busWord data;
		respCode resp;
		for (int polls = 0; polls < 100; polls++)
		begin
			axiRead(addrStatus, 0, data, resp);
			checkResp("status rResp", resp, respOkay);
			if (data[1])
				return;
		end
		abortRun("the layer never reported done within 100 status polls");
	endtask

	task automatic loadInputs(input logic readBack);
		busWord data;
		respCode resp;
		for (int i = 0; i < numInputs; i++)
		begin
			axiWrite(busAddr'(addrInputBase + 4 * i), busWord'(acts[i]), 0, resp);
			checkResp($sformatf("input %0d bResp", i), resp, respOkay);
		end
		for (int i = 0; readBack && i < numInputs; i++)
		begin
			axiRead(busAddr'(addrInputBase + 4 * i), 0, data, resp);
			checkResp($sformatf("input %0d rResp", i), resp, respOkay);
			checkWord($sformatf("input %0d", i), data, signExtended(acts[i]));
		end
	endtask

	// status right after start must show busy with done cleared
	task automatic startLayer();
		busWord data;
		respCode resp;
		axiWrite(addrControl, 32'h1, 0, resp);
		checkResp("start bResp", resp, respOkay);
		axiRead(addrStatus, 0, data, resp);
		checkResp("status rResp after start", resp, respOkay);
		checkWord("status after start", data, 32'h1);
	endtask

	task automatic checkResults();
		busWord data;
		respCode resp;
		for (int n = 0; n < numNeurons; n++)
		begin
			axiRead(busAddr'(addrResultBase + 4 * n), 0, data, resp);
			checkResp($sformatf("result %0d rResp", n), resp, respOkay);
			checkWord($sformatf("result %0d", n), data, signExtended(expectedResult(n)));
		end
	endtask

	task automatic resetStateTest();
		busWord data;
		respCode resp;
		axiRead(addrStatus, 0, data, resp);
		checkResp("status rResp after reset", resp, respOkay);
		checkWord("status after reset", data, 32'h0);
		for (int i = 0; i < numInputs; i++)
		begin
			axiRead(busAddr'(addrInputBase + 4 * i), 0, data, resp);
			checkResp("input rResp after reset", resp, respOkay);
			checkWord($sformatf("input %0d after reset", i), data, 32'h0);
		end
		// results keep their reset value until the first run
		for (int n = 0; n < numNeurons; n++)
		begin
			axiRead(busAddr'(addrResultBase + 4 * n), 0, data, resp);
			checkResp("result rResp after reset", resp, respOkay);
			checkWord($sformatf("result %0d after reset", n), data, 32'h0);
		end
	endtask

	task automatic directedTest();
		busWord data;
		respCode resp;
		// positive inputs drive neuron 0 up and neuron 3 below zero
		acts = '{16'sd10, 16'sd0, 16'sd10, 16'sd10, 16'sd0, 16'sd0, 16'sd10, 16'sd0};
		loadInputs(1'b1);
		startLayer();
		waitDone();
		checkResults();
		axiRead(addrResultBase + 8'h0C, 0, data, resp);
		checkWord("result 3 clipped", data, 32'h0);
		acts = '{-16'sd300, 16'sd250, -16'sd1, 16'sd32767,
			16'sh8000, 16'sd5, 16'sd123, -16'sd77};
		loadInputs(1'b1);
		startLayer();
		waitDone();
		checkResults();
	endtask

	task automatic randomTest();
		repeat (10)
		begin
			for (int i = 0; i < numInputs; i++)
				acts[i] = fixedWord'($random(seed));
			loadInputs(1'b0);
			startLayer();
			waitDone();
			checkResults();
		end
	endtask

	task automatic errorTest();
		busWord data;
		respCode resp;
		axiWrite(8'h28, 32'h5, 0, resp);
		checkResp("unmapped write bResp", resp, respSlvErr);
		axiWrite(8'hFC, 32'h5, 0, resp);
		checkResp("unmapped write bResp", resp, respSlvErr);
		axiRead(8'h30, 0, data, resp);
		checkResp("unmapped read rResp", resp, respSlvErr);
		checkWord("unmapped read rData", data, 32'h0);
		axiRead(8'h50, 0, data, resp);
		checkResp("unmapped read rResp", resp, respSlvErr);
		checkWord("unmapped read rData", data, 32'h0);
		axiRead(addrControl, 0, data, resp);
		checkResp("control read rResp", resp, respOkay);
		checkWord("control read rData", data, 32'h0);
		acts = '{16'sd7, -16'sd3, 16'sd12, 16'sd40, -16'sd9, 16'sd21, 16'sd2, 16'sd15};
		loadInputs(1'b0);
		startLayer();
		axiWrite(addrInputBase + 8'h08, 32'h1234, 0, resp);
		checkResp("input write while busy", resp, respSlvErr);
		axiWrite(addrControl, 32'h1, 0, resp);
		checkResp("second start while busy", resp, respOkay);
		waitDone();
		axiRead(addrInputBase + 8'h08, 0, data, resp);
		checkWord("input 2 after refused write", data, signExtended(acts[2]));
		checkResults();
	endtask

	task automatic backPressureTest();
		busWord data;
		respCode resp;
		acts[0] = -16'sd1234;
		axiWrite(addrInputBase, busWord'(acts[0]), 5, resp);
		checkResp("held write bResp", resp, respOkay);
		axiRead(addrInputBase, 6, data, resp);
		checkResp("held read rResp", resp, respOkay);
		checkWord("held read rData", data, signExtended(acts[0]));
		acts[1] = 16'sd321;
		axiWrite(addrInputBase + 8'h04, busWord'(acts[1]), 0, resp);
		checkResp("write after back-pressure", resp, respOkay);
		axiRead(addrInputBase + 8'h04, 0, data, resp);
		checkWord("read after back-pressure", data, signExtended(acts[1]));
	endtask

	initial
	begin
		seed = 94434;
		reset = 1'b1;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		resetStateTest();
		directedTest();
		randomTest();
		errorTest();
		backPressureTest();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/nnPkg.sv
hdl/activationBuffer.sv
hdl/neuronEngine.sv
hdl/axiLiteRegs.sv
hdl/nnLayer.sv
testbench/nnLayerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the nnLayer testbench with Verilator and runs it
# a failing check ends in $fatal, which gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module nnLayerTb \
	-f all.f \
	--Mdir obj_dir \
	-o nnLayerSim

./obj_dir/nnLayerSim

echo "run finished"
